// File: Bender.yml
package:
  name: tcb_access

sources:
  # packages first, then RTL in dependency order
  - files:
      - hdl/tcb_pkg.sv
      - hdl/tcb_access_pkg.sv
      - hdl/tcb_access_split.sv
      - hdl/tcb_slice.sv
      - hdl/tcb_mem.sv
      - hdl/tcb_access_top.sv
  - target: test
    files:
      - verification/tcb_access_tb.sv

// File: hdl/tcb_access_pkg.sv
`default_nettype none

package tcb_access_pkg;

  // log2 of access size in bytes (1, 2, 4)
  typedef logic [1:0] acc_siz_t;

  // size code 3 would be 8 bytes, rejected
  localparam acc_siz_t ACC_SIZ_ILL = 2'd3;

  // byte order of the access
  typedef enum logic {
    ACC_LITTLE = 1'b0,
    ACC_BIG    = 1'b1
  } acc_ndn_t;

  // worst case: misaligned access spanning two words
  localparam int unsigned ACC_MAX_XFER = 2;

  // transfer index width
  localparam int unsigned ACC_XIW = $clog2(ACC_MAX_XFER);
  // outstanding response counter width
  localparam int unsigned ACC_CNW = $clog2(ACC_MAX_XFER + 1);

  typedef logic [ACC_XIW-1:0] acc_xid_t;
  typedef logic [ACC_CNW-1:0] acc_cnt_t;

endpackage: tcb_access_pkg

`default_nettype wire

// File: hdl/tcb_access_split.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_access_split (
  // system
  input  logic                     tcb,
  input  logic                     arst_n,
  // access port, four-phase req/ack
  input  logic                     acc_req,
  input  logic                     acc_wen,
  input  tcb_pkg::tcb_adr_t        acc_adr,
  input  tcb_access_pkg::acc_siz_t acc_siz,
  input  tcb_access_pkg::acc_ndn_t acc_ndn,
  input  tcb_pkg::tcb_dat_t        acc_wdt,
  output logic                     acc_ack,
  output tcb_pkg::tcb_dat_t        acc_rdt,
  output logic                     acc_err,
  // tcb manager side
  output logic                     m_vld,
  input  logic                     m_rdy,
  output logic                     m_wen,
  output tcb_pkg::tcb_adr_t        m_adr,
  output tcb_pkg::tcb_ben_t        m_ben,
  output tcb_pkg::tcb_dat_t        m_wdt,
  input  logic                     m_rsp,
  input  tcb_pkg::tcb_dat_t        m_rdt,
  input  logic                     m_err
);
  import tcb_pkg::*;
  import tcb_access_pkg::*;

  // lane position across both words
  typedef logic [TCB_OFW:0] lane_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_ACK
  } state_t;

  state_t   state;
  acc_xid_t xfer_idx;
  acc_xid_t xfer_last;
  acc_xid_t rsp_idx;
  acc_cnt_t cnt_out;
  logic     err_acc;
  logic     trn;
  logic     done;
  tcb_dat_t rdw0;
  tcb_dat_t rdt_gat;

  // access geometry
  logic [TCB_OFW-1:0] ofs;
  lane_t              nbyt;
  lane_t              wr_lane;
  lane_t              rd_lane;

  // lane images of up to two words
  logic [ACC_MAX_XFER-1:0][TCB_BEW-1:0]              ben_w;
  logic [ACC_MAX_XFER-1:0][TCB_BEW-1:0][TCB_SLW-1:0] wdt_w;
  logic [ACC_MAX_XFER-1:0][TCB_BEW-1:0][TCB_SLW-1:0] rdt_w;

  // memory lane of access byte idx
  function automatic lane_t lane_of (
    input int unsigned        idx,
    input logic [TCB_OFW-1:0] off,
    input lane_t              num,
    input acc_ndn_t           ndn
  );
    lane_t pos;
    if (ndn == ACC_BIG) begin
      pos = num - lane_t'(idx) - lane_t'(1);
    end else begin
      pos = lane_t'(idx);
    end
    return lane_t'(off) + pos;
  endfunction: lane_of

  ////////////////////////////////////////////////////////////////////////////
  // request side lane mapping
  ////////////////////////////////////////////////////////////////////////////

  assign ofs  = acc_adr[TCB_OFW-1:0];
  // size code 3 wraps to zero, so no lanes
  assign nbyt = lane_t'(1) << acc_siz;

  always_comb begin
    ben_w   = '0;
    wdt_w   = '0;
    wr_lane = '0;
    for (int unsigned i = 0; i < TCB_BEW; i++) begin
      wr_lane = lane_of(i, ofs, nbyt, acc_ndn);
      if (i < nbyt) begin
        ben_w[wr_lane[TCB_OFW]][wr_lane[TCB_OFW-1:0]] = 1'b1;
        wdt_w[wr_lane[TCB_OFW]][wr_lane[TCB_OFW-1:0]] = acc_wdt[i*TCB_SLW +: TCB_SLW];
      end
    end
  end

  // any lane in the upper word means a second transfer
  assign xfer_last = acc_xid_t'(|ben_w[ACC_MAX_XFER-1]);

  // word aligned transfers, second one at the next word
  assign m_vld = (state == ST_ISSUE);
  assign m_wen = acc_wen;
  assign m_adr = {acc_adr[TCB_ABW-1:TCB_OFW] + (TCB_ABW-TCB_OFW)'(xfer_idx),
                  {TCB_OFW{1'b0}}};
  assign m_ben = ben_w[xfer_idx];
  assign m_wdt = wdt_w[xfer_idx];

  assign trn  = m_vld & m_rdy;
  // final response, everything issued and one left outstanding
  assign done = (state == ST_WAIT) && m_rsp && (cnt_out == acc_cnt_t'(1));

  ////////////////////////////////////////////////////////////////////////////
  // response side gathering
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // first word is live on a single transfer, stored otherwise
    rdt_w[0] = (rsp_idx == '0) ? m_rdt : rdw0;
    for (int unsigned x = 1; x < ACC_MAX_XFER; x++) begin
      rdt_w[x] = m_rdt;
    end
    rdt_gat = '0;
    rd_lane = '0;
    for (int unsigned i = 0; i < TCB_BEW; i++) begin
      rd_lane = lane_of(i, ofs, nbyt, acc_ndn);
      if (i < nbyt) begin
        rdt_gat[i*TCB_SLW +: TCB_SLW] = rdt_w[rd_lane[TCB_OFW]][rd_lane[TCB_OFW-1:0]];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      xfer_idx <= '0;
      rsp_idx  <= '0;
      cnt_out  <= '0;
      err_acc  <= 1'b0;
      acc_err  <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (acc_req) begin
            xfer_idx <= '0;
            rsp_idx  <= '0;
            cnt_out  <= '0;
            err_acc  <= 1'b0;
            // illegal size skips the bus
            if (acc_siz == ACC_SIZ_ILL) begin
              acc_err <= 1'b1;
              state   <= ST_ACK;
            end else begin
              state   <= ST_ISSUE;
            end
          end
        end
        ST_ISSUE, ST_WAIT: begin
          cnt_out <= cnt_out + acc_cnt_t'(trn) - acc_cnt_t'(m_rsp);
          if (trn) begin
            if (xfer_idx == xfer_last) begin
              state <= ST_WAIT;
            end else begin
              xfer_idx <= xfer_idx + acc_xid_t'(1);
            end
          end
          if (m_rsp) begin
            rsp_idx <= rsp_idx + acc_xid_t'(1);
            err_acc <= err_acc | m_err;
          end
          if (done) begin
            acc_err <= err_acc | m_err;
            state   <= ST_ACK;
          end
        end
        // hold ack until the requester lets go
        ST_ACK: begin
          if (!acc_req) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign acc_ack = (state == ST_ACK);

  // response payload
  always_ff @(posedge tcb) begin
    if (m_rsp && (rsp_idx == '0)) begin
      rdw0 <= m_rdt;
    end
    if (done) begin
      acc_rdt <= acc_wen ? '0 : rdt_gat;
    end else if ((state == ST_IDLE) && acc_req && (acc_siz == ACC_SIZ_ILL)) begin
      acc_rdt <= '0;
    end
  end

endmodule: tcb_access_split

`default_nettype wire

// File: hdl/tcb_access_top.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_access_top (
  // system
  input  logic                     tcb,
  input  logic                     arst_n,
  // access port
  input  logic                     acc_req,
  input  logic                     acc_wen,
  input  tcb_pkg::tcb_adr_t        acc_adr,
  input  tcb_access_pkg::acc_siz_t acc_siz,
  input  tcb_access_pkg::acc_ndn_t acc_ndn,
  input  tcb_pkg::tcb_dat_t        acc_wdt,
  output logic                     acc_ack,
  output tcb_pkg::tcb_dat_t        acc_rdt,
  output logic                     acc_err
);
  import tcb_pkg::*;

  // splitter to slice
  logic     m_vld;
  logic     m_rdy;
  logic     m_wen;
  tcb_adr_t m_adr;
  tcb_ben_t m_ben;
  tcb_dat_t m_wdt;

  // slice to memory
  logic     s_vld;
  logic     s_rdy;
  logic     s_wen;
  tcb_adr_t s_adr;
  tcb_ben_t s_ben;
  tcb_dat_t s_wdt;

  // response goes around the slice
  logic     rsp;
  tcb_dat_t rdt;
  logic     err;

  tcb_access_split split (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .acc_req (acc_req),
    .acc_wen (acc_wen),
    .acc_adr (acc_adr),
    .acc_siz (acc_siz),
    .acc_ndn (acc_ndn),
    .acc_wdt (acc_wdt),
    .acc_ack (acc_ack),
    .acc_rdt (acc_rdt),
    .acc_err (acc_err),
    .m_vld   (m_vld),
    .m_rdy   (m_rdy),
    .m_wen   (m_wen),
    .m_adr   (m_adr),
    .m_ben   (m_ben),
    .m_wdt   (m_wdt),
    .m_rsp   (rsp),
    .m_rdt   (rdt),
    .m_err   (err)
  );

  tcb_slice slice (
    .tcb    (tcb),
    .arst_n (arst_n),
    .i_vld  (m_vld),
    .i_rdy  (m_rdy),
    .i_wen  (m_wen),
    .i_adr  (m_adr),
    .i_ben  (m_ben),
    .i_wdt  (m_wdt),
    .o_vld  (s_vld),
    .o_rdy  (s_rdy),
    .o_wen  (s_wen),
    .o_adr  (s_adr),
    .o_ben  (s_ben),
    .o_wdt  (s_wdt)
  );

  tcb_mem mem (
    .tcb    (tcb),
    .arst_n (arst_n),
    .vld    (s_vld),
    .rdy    (s_rdy),
    .wen    (s_wen),
    .adr    (s_adr),
    .ben    (s_ben),
    .wdt    (s_wdt),
    .rsp    (rsp),
    .rdt    (rdt),
    .err    (err)
  );

endmodule: tcb_access_top

`default_nettype wire

// File: hdl/tcb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_mem (
  // system
  input  logic              tcb,
  input  logic              arst_n,
  // request
  input  logic              vld,
  output logic              rdy,
  input  logic              wen,
  input  tcb_pkg::tcb_adr_t adr,
  input  tcb_pkg::tcb_ben_t ben,
  input  tcb_pkg::tcb_dat_t wdt,
  // response
  output logic              rsp,
  output tcb_pkg::tcb_dat_t rdt,
  output logic              err
);
  import tcb_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // storage and decode
  ////////////////////////////////////////////////////////////////////////////

  tcb_dat_t mem [TCB_MEM_WORDS];

  logic [TCB_MEM_AW-1:0] idx;
  logic                  oor;
  logic                  trn;

  // response pipeline, stage 0 is the memory read
  logic [TCB_DLY-1:0] rsp_q;
  logic [TCB_DLY-1:0] err_q;
  tcb_dat_t           rdt_q [TCB_DLY];

  // never stalls
  assign rdy = 1'b1;
  assign trn = vld & rdy;

  // word index, lane bits dropped
  assign idx = adr[TCB_OFW +: TCB_MEM_AW];
  // any bit above 1 KiB
  assign oor = |(adr >> (TCB_OFW + TCB_MEM_AW));

  ////////////////////////////////////////////////////////////////////////////
  // response timing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      rsp_q <= '0;
      err_q <= '0;
    end else begin
      rsp_q[0] <= trn;
      err_q[0] <= trn & oor;
      for (int unsigned i = 1; i < TCB_DLY; i++) begin
        rsp_q[i] <= rsp_q[i-1];
        err_q[i] <= err_q[i-1];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (trn) begin
      // out of range writes are dropped
      if (wen && !oor) begin
        for (int unsigned b = 0; b < TCB_BEW; b++) begin
          if (ben[b]) begin
            mem[idx][b*TCB_SLW +: TCB_SLW] <= wdt[b*TCB_SLW +: TCB_SLW];
          end
        end
      end
      // whole word back, zero when out of range
      rdt_q[0] <= oor ? '0 : mem[idx];
    end
    for (int unsigned i = 1; i < TCB_DLY; i++) begin
      rdt_q[i] <= rdt_q[i-1];
    end
  end

  // last stage drives the link
  assign rsp = rsp_q[TCB_DLY-1];
  assign err = err_q[TCB_DLY-1];
  assign rdt = rdt_q[TCB_DLY-1];

endmodule: tcb_mem

`default_nettype wire

// File: hdl/tcb_pkg.sv
`default_nettype none

package tcb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // link widths
  ////////////////////////////////////////////////////////////////////////////

  // byte address width
  localparam int unsigned TCB_ABW = 16;
  // data word width
  localparam int unsigned TCB_DBW = 32;
  // byte width
  localparam int unsigned TCB_SLW = 8;
  // byte lanes per data word
  localparam int unsigned TCB_BEW = TCB_DBW / TCB_SLW;
  // byte offset bits within a word
  localparam int unsigned TCB_OFW = $clog2(TCB_BEW);

  // cycles from transfer edge to response
  localparam int unsigned TCB_DLY = 1;

  ////////////////////////////////////////////////////////////////////////////
  // memory subordinate
  ////////////////////////////////////////////////////////////////////////////

  // 1 KiB of storage
  localparam int unsigned TCB_MEM_WORDS = 256;
  // word index bits
  localparam int unsigned TCB_MEM_AW = $clog2(TCB_MEM_WORDS);

  // link vectors
  typedef logic [TCB_ABW-1:0] tcb_adr_t;
  typedef logic [TCB_DBW-1:0] tcb_dat_t;
  typedef logic [TCB_BEW-1:0] tcb_ben_t;

endpackage: tcb_pkg

`default_nettype wire

// File: hdl/tcb_slice.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_slice (
  // system
  input  logic              tcb,
  input  logic              arst_n,
  // upstream request
  input  logic              i_vld,
  output logic              i_rdy,
  input  logic              i_wen,
  input  tcb_pkg::tcb_adr_t i_adr,
  input  tcb_pkg::tcb_ben_t i_ben,
  input  tcb_pkg::tcb_dat_t i_wdt,
  // downstream request
  output logic              o_vld,
  input  logic              o_rdy,
  output logic              o_wen,
  output tcb_pkg::tcb_adr_t o_adr,
  output tcb_pkg::tcb_ben_t o_ben,
  output tcb_pkg::tcb_dat_t o_wdt
);
  import tcb_pkg::*;

  // two entry storage
  logic     ent_wen [2];
  tcb_adr_t ent_adr [2];
  tcb_ben_t ent_ben [2];
  tcb_dat_t ent_wdt [2];

  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] cnt;
  logic       push;
  logic       pop;

  // ready from registered occupancy only
  assign i_rdy = ~cnt[1];
  assign o_vld = |cnt;

  assign push = i_vld & i_rdy;
  assign pop  = o_vld & o_rdy;

  // oldest entry at the output
  assign o_wen = ent_wen[rd_ptr];
  assign o_adr = ent_adr[rd_ptr];
  assign o_ben = ent_ben[rd_ptr];
  assign o_wdt = ent_wdt[rd_ptr];

  // occupancy and pointers
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      cnt    <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // push and pop together keep the count
      cnt <= cnt + 2'(push) - 2'(pop);
    end
  end

  // payload
  always_ff @(posedge tcb) begin
    if (push) begin
      ent_wen[wr_ptr] <= i_wen;
      ent_adr[wr_ptr] <= i_adr;
      ent_ben[wr_ptr] <= i_ben;
      ent_wdt[wr_ptr] <= i_wdt;
    end
  end

endmodule: tcb_slice

`default_nettype wire

// File: tcb_access_top.f
hdl/tcb_pkg.sv
hdl/tcb_access_pkg.sv
hdl/tcb_access_split.sv
hdl/tcb_slice.sv
hdl/tcb_mem.sv
hdl/tcb_access_top.sv
verification/tcb_access_tb.sv

// File: verification/tcb_access_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tcb_access_tb;
  import tcb_pkg::*;
  import tcb_access_pkg::*;

  // cycles allowed for any single wait
  localparam int TIMEOUT   = 50;
  localparam int MEM_BYTES = TCB_MEM_WORDS * TCB_BEW;

  logic     tcb;
  logic     arst_n;
  logic     acc_req;
  logic     acc_wen;
  tcb_adr_t acc_adr;
  acc_siz_t acc_siz;
  acc_ndn_t acc_ndn;
  tcb_dat_t acc_wdt;
  logic     acc_ack;
  tcb_dat_t acc_rdt;
  logic     acc_err;

  // byte image of the memory
  logic [7:0]  ref_mem [MEM_BYTES];
  // sampled access result
  tcb_dat_t    got_rdt;
  logic        got_err;
  logic [31:0] lfsr;

  tcb_access_top uut (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .acc_req (acc_req),
    .acc_wen (acc_wen),
    .acc_adr (acc_adr),
    .acc_siz (acc_siz),
    .acc_ndn (acc_ndn),
    .acc_wdt (acc_wdt),
    .acc_ack (acc_ack),
    .acc_rdt (acc_rdt),
    .acc_err (acc_err)
  );

  initial begin
    tcb = 1'b0;
    forever #4 tcb = ~tcb;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // feedback polynomial x^32 + x^22 + x^2 + x + 1
  // one step for each bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // predicted result from the byte placement rules
  // writes update the byte image
  task automatic model(input logic wen, input tcb_adr_t adr, input acc_siz_t siz,
                       input acc_ndn_t ndn, input tcb_dat_t wdt,
                       output tcb_dat_t rdt, output logic err);
    int n;
    int a;
    rdt = '0;
    err = 1'b0;
    // 8 byte code is refused outright
    if (siz == 2'd3) begin
      err = 1'b1;
    end else begin
      n = 1 << siz;
      for (int i = 0; i < n; i++) begin
        a = (ndn == ACC_BIG) ? int'(adr) + n - 1 - i : int'(adr) + i;
        if (a >= MEM_BYTES) begin
          err = 1'b1;
        end else if (wen) begin
          ref_mem[a] = wdt[8*i +: 8];
        end else begin
          rdt[8*i +: 8] = ref_mem[a];
        end
      end
    end
  endtask

  // four-phase handshake on the access port
  task automatic access(input logic wen, input tcb_adr_t adr, input acc_siz_t siz,
                        input acc_ndn_t ndn, input tcb_dat_t wdt);
    int cyc;
    @(posedge tcb);
    acc_req <= 1'b1;
    acc_wen <= wen;
    acc_adr <= adr;
    acc_siz <= siz;
    acc_ndn <= ndn;
    acc_wdt <= wdt;
    cyc = 0;
    do begin
      @(posedge tcb);
      cyc++;
      if (cyc > TIMEOUT) begin
        abort_run("acc_ack never rose after acc_req");
      end
    end while (!acc_ack);
    got_rdt = acc_rdt;
    got_err = acc_err;
    acc_req <= 1'b0;
    // ack stays up until the dropped req is seen
    @(posedge tcb);
    check("ack hold", 32'd1, 32'(acc_ack));
    cyc = 0;
    do begin
      @(posedge tcb);
      cyc++;
      if (cyc > TIMEOUT) begin
        abort_run("acc_ack never fell after acc_req dropped");
      end
    end while (acc_ack);
  endtask

  task automatic run_access(input string name, input logic wen, input tcb_adr_t adr,
                            input acc_siz_t siz, input acc_ndn_t ndn, input tcb_dat_t wdt);
    tcb_dat_t exp_rdt;
    logic     exp_err;
    model(wen, adr, siz, ndn, wdt, exp_rdt, exp_err);
    access(wen, adr, siz, ndn, wdt);
    check({name, " rdt"}, exp_rdt, got_rdt);
    check({name, " err"}, 32'(exp_err), 32'(got_err));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  // known contents everywhere
  // pattern depends on the full address
  task automatic fill_memory();
    tcb_adr_t a;
    for (int w = 0; w < TCB_MEM_WORDS; w++) begin
      a = tcb_adr_t'(w * TCB_BEW);
      run_access("fill", 1'b1, a, 2'd2, ACC_LITTLE, {~a, a} ^ 32'h3c5a_96e1);
    end
  endtask

  task automatic test_aligned();
    run_access("aligned wr", 1'b1, 16'h0040, 2'd2, ACC_LITTLE, 32'hdead_beef);
    run_access("aligned rd", 1'b0, 16'h0040, 2'd2, ACC_LITTLE, '0);
    check("aligned value", 32'hdead_beef, got_rdt);
  endtask

  task automatic test_lanes();
    for (int o = 0; o < 4; o++) begin
      run_access("lane byte wr", 1'b1, tcb_adr_t'(16'h0100 + o), 2'd0, ACC_LITTLE,
                 32'h0000_00a0 + o);
      run_access("lane byte rd", 1'b0, 16'h0100, 2'd2, ACC_LITTLE, '0);
    end
    // halfwords that stay inside one word
    for (int o = 0; o < 3; o++) begin
      run_access("lane half wr", 1'b1, tcb_adr_t'(16'h0104 + o), 2'd1, ACC_LITTLE,
                 32'h0000_c0d0 + o);
      run_access("lane half rd", 1'b0, 16'h0104, 2'd2, ACC_LITTLE, '0);
    end
  endtask

  task automatic test_cross();
    tcb_adr_t base;
    acc_ndn_t ndn;
    for (int o = 1; o < 4; o++) begin
      for (int b = 0; b < 2; b++) begin
        base = tcb_adr_t'(16'h0200 + 32*o + 16*b);
        ndn  = b ? ACC_BIG : ACC_LITTLE;
        run_access("cross word wr", 1'b1, tcb_adr_t'(base + o), 2'd2, ndn,
                   32'h7162_5344 + o);
        run_access("cross word rd", 1'b0, tcb_adr_t'(base + o), 2'd2, ndn, '0);
        run_access("cross lo rd", 1'b0, base, 2'd2, ACC_LITTLE, '0);
        run_access("cross hi rd", 1'b0, tcb_adr_t'(base + 4), 2'd2, ACC_LITTLE, '0);
      end
    end
    run_access("cross half wr", 1'b1, 16'h02f3, 2'd1, ACC_LITTLE, 32'h0000_9876);
    run_access("cross half rd", 1'b0, 16'h02f3, 2'd1, ACC_BIG, '0);
    run_access("cross half be wr", 1'b1, 16'h02f7, 2'd1, ACC_BIG, 32'h0000_abcd);
    run_access("cross half be rd", 1'b0, 16'h02f7, 2'd1, ACC_BIG, '0);
  endtask

  task automatic test_endian();
    run_access("endian wr", 1'b1, 16'h0300, 2'd2, ACC_BIG, 32'h1122_3344);
    run_access("endian rd", 1'b0, 16'h0300, 2'd2, ACC_LITTLE, '0);
    check("endian swap", 32'h4433_2211, got_rdt);
    run_access("endian half wr", 1'b1, 16'h0306, 2'd1, ACC_BIG, 32'h0000_a1b2);
    run_access("endian half rd", 1'b0, 16'h0306, 2'd1, ACC_LITTLE, '0);
    check("endian half swap", 32'h0000_b2a1, got_rdt);
  endtask

  task automatic test_range();
    run_access("oor wr", 1'b1, 16'h0400, 2'd2, ACC_LITTLE, 32'hcafe_f00d);
    run_access("oor rd", 1'b0, 16'h8000, 2'd2, ACC_LITTLE, '0);
    // dropped write must not wrap onto word 0
    run_access("alias rd", 1'b0, 16'h0000, 2'd2, ACC_LITTLE, '0);
    run_access("limit half wr", 1'b1, 16'h03ff, 2'd1, ACC_LITTLE, 32'h0000_5a5a);
    run_access("limit word wr", 1'b1, 16'h03fd, 2'd2, ACC_BIG, 32'h0102_0304);
    run_access("limit nbr rd", 1'b0, 16'h03f8, 2'd2, ACC_LITTLE, '0);
    run_access("limit last rd", 1'b0, 16'h03fc, 2'd2, ACC_LITTLE, '0);
    run_access("limit cross rd", 1'b0, 16'h03fe, 2'd2, ACC_LITTLE, '0);
    run_access("ill size wr", 1'b1, 16'h0010, 2'd3, ACC_LITTLE, 32'hffff_ffff);
    run_access("ill size rd", 1'b0, 16'h0010, 2'd3, ACC_BIG, '0);
    run_access("ill size nbr", 1'b0, 16'h0010, 2'd2, ACC_LITTLE, '0);
  endtask

  task automatic test_random();
    acc_siz_t siz;
    int       n;
    int       a;
    for (int k = 0; k < 200; k++) begin
      siz = acc_siz_t'(rand_bits(2) % 3);
      n   = 1 << siz;
      a   = int'(rand_bits(10));
      // keep the whole access below 1 KiB
      if (a + n > MEM_BYTES) begin
        a = MEM_BYTES - n;
      end
      run_access($sformatf("random %0d", k), rand_bits(1) == 1, tcb_adr_t'(a), siz,
                 rand_bits(1) ? ACC_BIG : ACC_LITTLE, rand_bits(32));
    end
  endtask

  initial begin
    lfsr    = 32'hd4e46783;
    arst_n  = 1'b0;
    acc_req = 1'b0;
    acc_wen = 1'b0;
    acc_adr = '0;
    acc_siz = '0;
    acc_ndn = ACC_LITTLE;
    acc_wdt = '0;
    repeat (10) @(posedge tcb);
    arst_n <= 1'b1;
    @(posedge tcb);
    check("reset ack", 32'd0, 32'(acc_ack));
    fill_memory();
    test_aligned();
    test_lanes();
    test_cross();
    test_endian();
    test_range();
    test_random();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire
